//--- source/csrPkg.sv
`default_nettype none

package csrPkg;

  localparam int XLEN = 32;
  localparam int CounterWidth = 64;
  localparam int RETIRE_WIDTH = 2;

  typedef logic [XLEN-1:0] xlenT;
  typedef logic [CounterWidth-1:0] counterT;
  typedef logic [11:0] csrAddrT;
  typedef logic [4:0] causeT;

  localparam xlenT MARCH_ID = 32'h0000_0019;

  // mstatus field positions
  localparam int MSTATUS_MIE = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP = 11; // lsb of the two bit field

  localparam xlenT COUNTER_MASK = 32'h0000_0005; // cy and ir only

  localparam causeT IRQ_TIMER = 5'd7;
  localparam causeT IRQ_EXTERNAL = 5'd11;

  typedef enum logic [1:0] {
    PRIV_USER    = 2'd0,
    PRIV_MACHINE = 2'd3
  } privLevelT;

  typedef enum logic [11:0] {
    ADDR_MSTATUS       = 12'h300,
    ADDR_MISA          = 12'h301,
    ADDR_MIE           = 12'h304,
    ADDR_MTVEC         = 12'h305,
    ADDR_MCOUNTEREN    = 12'h306,
    ADDR_MCOUNTINHIBIT = 12'h320,
    ADDR_MSCRATCH      = 12'h340,
    ADDR_MEPC          = 12'h341,
    ADDR_MCAUSE        = 12'h342,
    ADDR_MTVAL         = 12'h343,
    ADDR_MIP           = 12'h344,
    ADDR_MCYCLE        = 12'hB00,
    ADDR_MINSTRET      = 12'hB02,
    ADDR_MCYCLEH       = 12'hB80,
    ADDR_MINSTRETH     = 12'hB82,
    ADDR_CYCLE         = 12'hC00,
    ADDR_INSTRET       = 12'hC02,
    ADDR_CYCLEH        = 12'hC80,
    ADDR_INSTRETH      = 12'hC82,
    ADDR_MVENDORID     = 12'hF11,
    ADDR_MARCHID       = 12'hF12,
    ADDR_MIMPID        = 12'hF13,
    ADDR_MHARTID       = 12'hF14
  } csrAddrE;

  typedef enum logic [2:0] {
    CSR_R, CSR_RW, CSR_RS, CSR_RC, CSR_RW_I, CSR_RS_I, CSR_RC_I, CSR_MRET
  } csrOpcodeE;

  typedef enum logic [1:0] {
    FLAGS_NONE, FLAGS_ILLEGAL, FLAGS_XRET, FLAGS_ORDERING
  } resultFlagsE;

  typedef struct packed {
    logic valid;
    csrOpcodeE opcode;
    csrAddrT addr;
    xlenT srcA;
    logic [4:0] zimm;
    logic wantResult;
  } csrOpT;

  typedef struct packed {
    logic valid;
    resultFlagsE flags;
    xlenT data;
  } csrResultT;

  typedef struct packed {
    logic valid;
    logic isInterrupt;
    causeT cause;
    xlenT pc;
    xlenT tval;
  } trapEntryT;

  typedef struct packed {
    privLevelT priv;
    logic [XLEN-3:0] mtvecBase;
    logic [XLEN-2:0] retvec;
    logic interruptPending;
    causeT interruptCause;
  } trapControlT;

  typedef struct packed {
    logic enable;
    csrAddrT addr;
    xlenT data;
  } csrWriteT;

endpackage

`default_nettype wire

//--- source/csrReadMux.sv
`timescale 1ns/1ps
`default_nettype none

module csrReadMux (
  input  wire csrPkg::csrAddrT addr,
  input  wire csrPkg::privLevelT priv,
  input  wire csrPkg::xlenT mcounteren,
  input  wire csrPkg::xlenT mstatus,
  input  wire csrPkg::xlenT mtvec,
  input  wire csrPkg::xlenT mepc,
  input  wire csrPkg::xlenT mcause,
  input  wire csrPkg::xlenT mtval,
  input  wire csrPkg::xlenT mscratch,
  input  wire csrPkg::xlenT mie,
  input  wire csrPkg::xlenT mip,
  input  wire csrPkg::xlenT mcountinhibit,
  input  wire csrPkg::counterT mcycle,
  input  wire csrPkg::counterT minstret,
  output csrPkg::xlenT readData,
  output logic readIllegal
);

  logic userMode;
  logic cycleBlocked;
  logic instretBlocked;

  assign userMode = priv == csrPkg::PRIV_USER;
  assign cycleBlocked = userMode && !mcounteren[0];   // cy enable
  assign instretBlocked = userMode && !mcounteren[2]; // ir enable

  always_comb begin
    readData = '0;
    readIllegal = 1'b0;
    case (csrPkg::csrAddrE'(addr))
      csrPkg::ADDR_MSTATUS:       readData = mstatus;
      csrPkg::ADDR_MIE:           readData = mie;
      csrPkg::ADDR_MTVEC:         readData = mtvec;
      csrPkg::ADDR_MCOUNTEREN:    readData = mcounteren;
      csrPkg::ADDR_MCOUNTINHIBIT: readData = mcountinhibit;
      csrPkg::ADDR_MSCRATCH:      readData = mscratch;
      csrPkg::ADDR_MEPC:          readData = mepc;
      csrPkg::ADDR_MCAUSE:        readData = mcause;
      csrPkg::ADDR_MTVAL:         readData = mtval;
      csrPkg::ADDR_MIP:           readData = mip;
      csrPkg::ADDR_MCYCLE:        readData = mcycle[csrPkg::XLEN-1:0];
      csrPkg::ADDR_MINSTRET:      readData = minstret[csrPkg::XLEN-1:0];
      csrPkg::ADDR_MCYCLEH:       readData = mcycle[csrPkg::CounterWidth-1:csrPkg::XLEN];
      csrPkg::ADDR_MINSTRETH:     readData = minstret[csrPkg::CounterWidth-1:csrPkg::XLEN];
      // user shadows, gated by mcounteren
      csrPkg::ADDR_CYCLE: begin
        readData = mcycle[csrPkg::XLEN-1:0];
        readIllegal = cycleBlocked;
      end
      csrPkg::ADDR_CYCLEH: begin
        readData = mcycle[csrPkg::CounterWidth-1:csrPkg::XLEN];
        readIllegal = cycleBlocked;
      end
      csrPkg::ADDR_INSTRET: begin
        readData = minstret[csrPkg::XLEN-1:0];
        readIllegal = instretBlocked;
      end
      csrPkg::ADDR_INSTRETH: begin
        readData = minstret[csrPkg::CounterWidth-1:csrPkg::XLEN];
        readIllegal = instretBlocked;
      end
      csrPkg::ADDR_MARCHID:       readData = csrPkg::MARCH_ID;
      csrPkg::ADDR_MISA,
      csrPkg::ADDR_MVENDORID,
      csrPkg::ADDR_MIMPID,
      csrPkg::ADDR_MHARTID:       readData = '0; // read-only zero
      default:                    readIllegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- source/csrCounters.sv
`timescale 1ns/1ps
`default_nettype none

module csrCounters (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic [csrPkg::RETIRE_WIDTH-1:0] retire,
  input  wire csrPkg::csrWriteT write,
  output csrPkg::counterT mcycle,
  output csrPkg::counterT minstret,
  output csrPkg::xlenT mcountinhibit
);

  logic [$clog2(csrPkg::RETIRE_WIDTH+1)-1:0] retireCount;
  logic cycleLoWr;
  logic cycleHiWr;
  logic instretLoWr;
  logic instretHiWr;
  logic inhibitWr;

  always_comb begin
    retireCount = '0;
    for (int i = 0; i < csrPkg::RETIRE_WIDTH; i++) begin
      if (retire[i]) retireCount++;
    end
  end

  assign cycleLoWr = write.enable && write.addr == csrPkg::ADDR_MCYCLE;
  assign cycleHiWr = write.enable && write.addr == csrPkg::ADDR_MCYCLEH;
  assign instretLoWr = write.enable && write.addr == csrPkg::ADDR_MINSTRET;
  assign instretHiWr = write.enable && write.addr == csrPkg::ADDR_MINSTRETH;
  assign inhibitWr = write.enable && write.addr == csrPkg::ADDR_MCOUNTINHIBIT;

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle <= '0;
      minstret <= '0;
      mcountinhibit <= '0;
    end else begin
      // a software write replaces the increment for that cycle
      if (cycleLoWr) mcycle[csrPkg::XLEN-1:0] <= write.data;
      else if (cycleHiWr) mcycle[csrPkg::CounterWidth-1:csrPkg::XLEN] <= write.data;
      else if (!mcountinhibit[0]) mcycle <= mcycle + csrPkg::counterT'(1);

      if (instretLoWr) minstret[csrPkg::XLEN-1:0] <= write.data;
      else if (instretHiWr) minstret[csrPkg::CounterWidth-1:csrPkg::XLEN] <= write.data;
      else if (!mcountinhibit[2]) minstret <= minstret + csrPkg::counterT'(retireCount);

      if (inhibitWr) mcountinhibit <= write.data & csrPkg::COUNTER_MASK; // tm bit stays 0
    end
  end

  instretStep: assert property (@(posedge clk) disable iff (rst)
    !(instretLoWr || instretHiWr) |=>
      (minstret - $past(minstret)) <= csrPkg::counterT'(csrPkg::RETIRE_WIDTH));

endmodule

`default_nettype wire

//--- source/interruptCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module interruptCtrl (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic irq,
  input  wire csrPkg::counterT mtime,
  input  wire csrPkg::counterT mtimecmp,
  input  wire csrPkg::csrWriteT write,
  input  wire csrPkg::privLevelT priv,
  input  wire logic globalEnable,
  output csrPkg::xlenT mie,
  output csrPkg::xlenT mip,
  output logic interruptPending,
  output csrPkg::causeT interruptCause
);

  csrPkg::xlenT active;
  logic unmasked;

  always_ff @(posedge clk) begin
    if (rst) begin
      mip <= '0;
      mie <= '0;
    end else begin
      mip[csrPkg::IRQ_TIMER] <= mtime >= mtimecmp;
      mip[csrPkg::IRQ_EXTERNAL] <= irq;
      if (write.enable && write.addr == csrPkg::ADDR_MIE) begin
        mie[csrPkg::IRQ_TIMER] <= write.data[csrPkg::IRQ_TIMER];       // mtie
        mie[csrPkg::IRQ_EXTERNAL] <= write.data[csrPkg::IRQ_EXTERNAL]; // meie
      end
    end
  end

  assign active = mip & mie;

  // user mode always takes machine interrupts
  assign unmasked = priv == csrPkg::PRIV_USER || globalEnable;

  always_comb begin
    interruptPending = 1'b0;
    interruptCause = '0;
    if (unmasked && active[csrPkg::IRQ_EXTERNAL]) begin
      interruptPending = 1'b1;
      interruptCause = csrPkg::IRQ_EXTERNAL;
    end else if (unmasked && active[csrPkg::IRQ_TIMER]) begin
      interruptPending = 1'b1;
      interruptCause = csrPkg::IRQ_TIMER;
    end
  end

  // a pending cause must trace back to a source seen one edge earlier
  pendingSource: assert property (@(posedge clk) disable iff (rst)
    interruptPending |->
      (interruptCause == csrPkg::IRQ_EXTERNAL && $past(irq)) ||
      (interruptCause == csrPkg::IRQ_TIMER && $past(mtime >= mtimecmp)));

endmodule

`default_nettype wire

//--- source/machineTrapRegs.sv
`timescale 1ns/1ps
`default_nettype none

module machineTrapRegs (
  input  wire logic clk,
  input  wire logic rst,
  input  wire csrPkg::trapEntryT trap,
  input  wire csrPkg::csrWriteT write,
  input  wire logic mret,
  output csrPkg::privLevelT priv,
  output csrPkg::xlenT mstatus,
  output csrPkg::xlenT mtvec,
  output csrPkg::xlenT mepc,
  output csrPkg::xlenT mcause,
  output csrPkg::xlenT mtval,
  output csrPkg::xlenT mscratch,
  output csrPkg::xlenT mcounteren,
  output logic [csrPkg::XLEN-2:0] retvec
);

  csrPkg::xlenT mstatusWr;

  // only mie, mpie and mpp exist
  always_comb begin
    mstatusWr = '0;
    mstatusWr[csrPkg::MSTATUS_MIE] = write.data[csrPkg::MSTATUS_MIE];
    mstatusWr[csrPkg::MSTATUS_MPIE] = write.data[csrPkg::MSTATUS_MPIE];
    // unsupported modes fall back to user
    if (write.data[csrPkg::MSTATUS_MPP +: 2] == csrPkg::PRIV_MACHINE) begin
      mstatusWr[csrPkg::MSTATUS_MPP +: 2] = csrPkg::PRIV_MACHINE;
    end else begin
      mstatusWr[csrPkg::MSTATUS_MPP +: 2] = csrPkg::PRIV_USER;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      priv <= csrPkg::PRIV_MACHINE;
      mstatus <= '0;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
      mtval <= '0;
      mscratch <= '0;
      mcounteren <= '0;
      retvec <= '0;
    end else if (trap.valid) begin
      mstatus[csrPkg::MSTATUS_MPIE] <= mstatus[csrPkg::MSTATUS_MIE];
      mstatus[csrPkg::MSTATUS_MIE] <= 1'b0;
      mstatus[csrPkg::MSTATUS_MPP +: 2] <= priv;
      mepc <= {trap.pc[csrPkg::XLEN-1:1], 1'b0};
      mcause <= {trap.isInterrupt, {(csrPkg::XLEN-6){1'b0}}, trap.cause};
      mtval <= trap.tval; // supplied by the trap source
      priv <= csrPkg::PRIV_MACHINE;
    end else if (mret) begin
      mstatus[csrPkg::MSTATUS_MIE] <= mstatus[csrPkg::MSTATUS_MPIE];
      mstatus[csrPkg::MSTATUS_MPIE] <= 1'b1;
      mstatus[csrPkg::MSTATUS_MPP +: 2] <= csrPkg::PRIV_USER;
      priv <= csrPkg::privLevelT'(mstatus[csrPkg::MSTATUS_MPP +: 2]);
      retvec <= mepc[csrPkg::XLEN-1:1];
    end else if (write.enable) begin
      case (write.addr)
        csrPkg::ADDR_MSTATUS:    mstatus <= mstatusWr;
        csrPkg::ADDR_MTVEC:      mtvec <= {write.data[csrPkg::XLEN-1:2], 2'b00}; // direct mode
        csrPkg::ADDR_MEPC:       mepc <= {write.data[csrPkg::XLEN-1:1], 1'b0};
        csrPkg::ADDR_MCAUSE: begin
          mcause <= {write.data[csrPkg::XLEN-1], {(csrPkg::XLEN-6){1'b0}}, write.data[4:0]};
        end
        csrPkg::ADDR_MTVAL:      mtval <= write.data;
        csrPkg::ADDR_MSCRATCH:   mscratch <= write.data;
        csrPkg::ADDR_MCOUNTEREN: mcounteren <= write.data & csrPkg::COUNTER_MASK;
        default: ;
      endcase
    end
  end

  // csrOpExec must drop the op when the commit stage traps
  trapBeatsWrite: assert property (@(posedge clk) disable iff (rst)
    !(trap.valid && (write.enable || mret)));

endmodule

`default_nettype wire

//--- source/csrOpExec.sv
`timescale 1ns/1ps
`default_nettype none

module csrOpExec (
  input  wire logic clk,
  input  wire logic rst,
  input  wire csrPkg::csrOpT op,
  input  wire logic trapValid,
  input  wire csrPkg::privLevelT priv,
  input  wire csrPkg::xlenT readData,
  input  wire logic readIllegal,
  output csrPkg::csrWriteT write,
  output logic mret,
  output csrPkg::csrResultT result
);

  logic accept;
  logic isMret;
  logic doesWrite;
  logic illegal;
  csrPkg::xlenT source;
  csrPkg::xlenT writeData;
  csrPkg::resultFlagsE flags;
  logic resultValid;
  csrPkg::resultFlagsE resultFlags;
  csrPkg::xlenT resultData;

  assign accept = op.valid && !trapValid; // trap wins, op is dropped
  assign isMret = op.opcode == csrPkg::CSR_MRET;
  assign doesWrite = !(op.opcode inside {csrPkg::CSR_R, csrPkg::CSR_MRET});

  always_comb begin
    case (op.opcode)
      csrPkg::CSR_RW_I, csrPkg::CSR_RS_I, csrPkg::CSR_RC_I: source = csrPkg::xlenT'(op.zimm);
      default: source = op.srcA;
    endcase
    case (op.opcode)
      csrPkg::CSR_RS, csrPkg::CSR_RS_I: writeData = readData | source;
      csrPkg::CSR_RC, csrPkg::CSR_RC_I: writeData = readData & ~source;
      default: writeData = source;
    endcase
  end

  always_comb begin
    if (isMret) begin
      illegal = priv != csrPkg::PRIV_MACHINE;
    end else begin
      illegal = (priv < op.addr[9:8]) || readIllegal ||
                (doesWrite && op.addr[11:10] == 2'b11); // read-only space
    end
  end

  always_comb begin
    if (illegal) flags = csrPkg::FLAGS_ILLEGAL;
    else if (isMret) flags = csrPkg::FLAGS_XRET;
    else if (doesWrite && op.addr inside {csrPkg::ADDR_MSTATUS, csrPkg::ADDR_MIE,
                                          csrPkg::ADDR_MCOUNTEREN}) begin
      flags = csrPkg::FLAGS_ORDERING; // state read implicitly by the pipeline
    end else flags = csrPkg::FLAGS_NONE;
  end

  always_comb begin
    write.enable = accept && doesWrite && !illegal;
    write.addr = op.addr;
    write.data = writeData;
  end

  assign mret = accept && isMret && !illegal;

  always_ff @(posedge clk) begin
    if (rst) resultValid <= 1'b0;
    else resultValid <= accept;
  end

  always_ff @(posedge clk) begin
    resultFlags <= flags;
    resultData <= (op.wantResult && !illegal) ? readData : '0;
  end

  assign result = '{valid: resultValid, flags: resultFlags, data: resultData};

endmodule

`default_nettype wire

//--- source/csrUnit.sv
`timescale 1ns/1ps
`default_nettype none

module csrUnit (
  input  wire logic clk,
  input  wire logic rst,
  input  wire csrPkg::csrOpT op,
  input  wire csrPkg::trapEntryT trap,
  input  wire logic [csrPkg::RETIRE_WIDTH-1:0] retire,
  input  wire logic irq,
  input  wire csrPkg::counterT mtime,
  input  wire csrPkg::counterT mtimecmp,
  output csrPkg::csrResultT result,
  output csrPkg::trapControlT trapControl
);

  csrPkg::csrWriteT write;
  logic mret;
  csrPkg::privLevelT priv;
  csrPkg::xlenT readData;
  logic readIllegal;
  csrPkg::xlenT mstatus, mtvec, mepc, mcause, mtval, mscratch, mcounteren;
  csrPkg::xlenT mie, mip, mcountinhibit;
  csrPkg::counterT mcycle, minstret;
  logic [csrPkg::XLEN-2:0] retvec;
  logic interruptPending;
  csrPkg::causeT interruptCause;

  csrOpExec exec (
    .clk(clk), .rst(rst), .op(op), .trapValid(trap.valid), .priv(priv),
    .readData(readData), .readIllegal(readIllegal),
    .write(write), .mret(mret), .result(result)
  );

  csrReadMux readMux (
    .addr(op.addr), .priv(priv), .mcounteren(mcounteren),
    .mstatus(mstatus), .mtvec(mtvec), .mepc(mepc), .mcause(mcause), .mtval(mtval),
    .mscratch(mscratch), .mie(mie), .mip(mip), .mcountinhibit(mcountinhibit),
    .mcycle(mcycle), .minstret(minstret),
    .readData(readData), .readIllegal(readIllegal)
  );

  csrCounters counters (
    .clk(clk), .rst(rst), .retire(retire), .write(write),
    .mcycle(mcycle), .minstret(minstret), .mcountinhibit(mcountinhibit)
  );

  interruptCtrl intCtrl (
    .clk(clk), .rst(rst), .irq(irq), .mtime(mtime), .mtimecmp(mtimecmp),
    .write(write), .priv(priv), .globalEnable(mstatus[csrPkg::MSTATUS_MIE]),
    .mie(mie), .mip(mip),
    .interruptPending(interruptPending), .interruptCause(interruptCause)
  );

  machineTrapRegs trapRegs (
    .clk(clk), .rst(rst), .trap(trap), .write(write), .mret(mret),
    .priv(priv), .mstatus(mstatus), .mtvec(mtvec), .mepc(mepc), .mcause(mcause),
    .mtval(mtval), .mscratch(mscratch), .mcounteren(mcounteren), .retvec(retvec)
  );

  assign trapControl = '{
    priv: priv,
    mtvecBase: mtvec[csrPkg::XLEN-1:2],
    retvec: retvec,
    interruptPending: interruptPending,
    interruptCause: interruptCause
  };

endmodule

`default_nettype wire

//--- verification/csrUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module csrUnitTb;

  typedef enum logic [1:0] {
    ROW_IDLE,
    ROW_OP,
    ROW_TRAP
  } rowKindE;

  // one table row with its stimulus and the state expected after its edge
  typedef struct packed {
    rowKindE kind;
    csrPkg::csrOpcodeE opcode;
    csrPkg::csrAddrT addr;
    csrPkg::xlenT src;           // srcA or the trap pc
    logic [4:0] zimm;
    logic wantResult;
    logic isInterrupt;
    csrPkg::causeT cause;
    csrPkg::xlenT tval;
    logic [csrPkg::RETIRE_WIDTH-1:0] retire;
    logic irq;
    logic timerHit;
    csrPkg::resultFlagsE expFlags;
    csrPkg::xlenT expData;
    csrPkg::privLevelT expPriv;
    logic expPending;
    csrPkg::causeT expCause;
    logic [csrPkg::XLEN-2:0] expRetvec;
    logic [csrPkg::XLEN-3:0] expMtvecBase;
  } stimRowT;

  logic clk = 1'b0;
  logic rst;
  csrPkg::csrOpT op;
  csrPkg::trapEntryT trap;
  logic [csrPkg::RETIRE_WIDTH-1:0] retire;
  logic irq;
  csrPkg::counterT mtime;
  csrPkg::counterT mtimecmp;
  csrPkg::csrResultT result;
  csrPkg::trapControlT trapControl;

  stimRowT stimTable[$];
  integer seed;
  csrPkg::xlenT d [6];
  int cycleCount = 0;
  int timeoutLimit = 1000;

  // levels and expectations carried from row to row while building
  logic [csrPkg::RETIRE_WIDTH-1:0] retireLevel;
  logic irqLevel;
  logic timerLevel;
  csrPkg::privLevelT expPriv;
  logic expPending;
  csrPkg::causeT expCause;
  logic [csrPkg::XLEN-2:0] expRetvec;
  logic [csrPkg::XLEN-3:0] expMtvecBase;

  csrUnit uut (
    .clk(clk), .rst(rst), .op(op), .trap(trap), .retire(retire), .irq(irq),
    .mtime(mtime), .mtimecmp(mtimecmp), .result(result), .trapControl(trapControl)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout: the table did not finish within %0d cycles", timeoutLimit);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic stimRowT makeRow(input rowKindE kind);
    stimRowT r;
    r = '0;
    r.kind = kind;
    r.retire = retireLevel;
    r.irq = irqLevel;
    r.timerHit = timerLevel;
    r.expPriv = expPriv;
    r.expPending = expPending;
    r.expCause = expCause;
    r.expRetvec = expRetvec;
    r.expMtvecBase = expMtvecBase;
    return r;
  endfunction

  task automatic addOp(input csrPkg::csrOpcodeE opcode, input csrPkg::csrAddrE addr,
                       input csrPkg::xlenT src, input logic [4:0] zimm, input logic wantResult,
                       input csrPkg::resultFlagsE flags, input csrPkg::xlenT data);
    stimRowT r;
    r = makeRow(ROW_OP);
    r.opcode = opcode;
    r.addr = addr;
    r.src = src;
    r.zimm = zimm;
    r.wantResult = wantResult;
    r.expFlags = flags;
    r.expData = data;
    stimTable.push_back(r);
  endtask

  task automatic addRead(input csrPkg::csrAddrE addr, input csrPkg::resultFlagsE flags,
                         input csrPkg::xlenT data);
    addOp(csrPkg::CSR_R, addr, 32'd0, 5'd0, 1'b1, flags, data);
  endtask

  task automatic addMret(input csrPkg::resultFlagsE flags);
    addOp(csrPkg::CSR_MRET, csrPkg::ADDR_MSCRATCH, 32'd0, 5'd0, 1'b0, flags, 32'd0);
  endtask

  task automatic addTrap(input logic isInterrupt, input csrPkg::causeT cause,
                         input csrPkg::xlenT pc, input csrPkg::xlenT tval);
    stimRowT r;
    r = makeRow(ROW_TRAP);
    r.isInterrupt = isInterrupt;
    r.cause = cause;
    r.src = pc;
    r.tval = tval;
    stimTable.push_back(r);
  endtask

  task automatic buildTable();
    logic [4:0] z0;
    logic [4:0] z1;
    logic [4:0] z2;
    seed = 32'hc00231bf;
    for (int k = 0; k < 6; k++) d[k] = $random(seed);
    z0 = d[3][4:0];
    z1 = d[3][9:5];
    z2 = d[3][14:10];
    retireLevel = '0;
    irqLevel = 1'b0;
    timerLevel = 1'b0;
    expPriv = csrPkg::PRIV_MACHINE;
    expPending = 1'b0;
    expCause = '0;
    expRetvec = '0;
    expMtvecBase = '0;
    stimTable.push_back(makeRow(ROW_IDLE)); // state right after reset

    // six write forms on mscratch return the old value
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MSCRATCH, d[0], 5'd0, 1'b1, csrPkg::FLAGS_NONE, 32'd0);
    addRead(csrPkg::ADDR_MSCRATCH, csrPkg::FLAGS_NONE, d[0]);
    addOp(csrPkg::CSR_RS, csrPkg::ADDR_MSCRATCH, d[1], 5'd0, 1'b1, csrPkg::FLAGS_NONE, d[0]);
    addOp(csrPkg::CSR_RC, csrPkg::ADDR_MSCRATCH, d[2], 5'd0, 1'b1, csrPkg::FLAGS_NONE,
          d[0] | d[1]);
    addOp(csrPkg::CSR_RW_I, csrPkg::ADDR_MSCRATCH, 32'd0, z0, 1'b1, csrPkg::FLAGS_NONE,
          (d[0] | d[1]) & ~d[2]);
    addOp(csrPkg::CSR_RS_I, csrPkg::ADDR_MSCRATCH, 32'd0, z1, 1'b1, csrPkg::FLAGS_NONE,
          {27'd0, z0});
    addOp(csrPkg::CSR_RC_I, csrPkg::ADDR_MSCRATCH, 32'd0, z2, 1'b1, csrPkg::FLAGS_NONE,
          {27'd0, z0 | z1});
    addRead(csrPkg::ADDR_MSCRATCH, csrPkg::FLAGS_NONE, {27'd0, (z0 | z1) & ~z2});
    addOp(csrPkg::CSR_R, csrPkg::ADDR_MSCRATCH, 32'd0, 5'd0, 1'b0, csrPkg::FLAGS_NONE, 32'd0);
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MIE, 32'h880, 5'd0, 1'b1, csrPkg::FLAGS_ORDERING, 32'd0);
    addRead(csrPkg::ADDR_MIE, csrPkg::FLAGS_NONE, 32'h880);
    addOp(csrPkg::CSR_RS, csrPkg::ADDR_MSTATUS, 32'h8, 5'd0, 1'b1, csrPkg::FLAGS_ORDERING, 32'd0);
    addRead(csrPkg::ADDR_MSTATUS, csrPkg::FLAGS_NONE, 32'h8);
    // marchid is read-only even in machine mode
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MARCHID, d[2], 5'd0, 1'b1, csrPkg::FLAGS_ILLEGAL, 32'd0);
    expMtvecBase = d[4][31:2];
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MTVEC, d[4], 5'd0, 1'b1, csrPkg::FLAGS_NONE, 32'd0);

    // exception then interrupt trap from machine mode
    addTrap(1'b0, 5'd2, d[5], d[0]);
    addRead(csrPkg::ADDR_MEPC, csrPkg::FLAGS_NONE, {d[5][31:1], 1'b0});
    addRead(csrPkg::ADDR_MCAUSE, csrPkg::FLAGS_NONE, 32'd2);
    addRead(csrPkg::ADDR_MTVAL, csrPkg::FLAGS_NONE, d[0]);
    addRead(csrPkg::ADDR_MSTATUS, csrPkg::FLAGS_NONE, 32'h1880); // mpp=M, mpie=1
    addTrap(1'b1, 5'd11, d[1], 32'd0);
    addRead(csrPkg::ADDR_MCAUSE, csrPkg::FLAGS_NONE, 32'h8000_000b);
    addRead(csrPkg::ADDR_MSTATUS, csrPkg::FLAGS_NONE, 32'h1800);

    // counters with mcycle frozen by inhibit bit 0
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MCOUNTINHIBIT, 32'h1, 5'd0, 1'b1, csrPkg::FLAGS_NONE,
          32'd0);
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MCYCLE, d[4], 5'd0, 1'b0, csrPkg::FLAGS_NONE, 32'd0);
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MCYCLEH, d[5], 5'd0, 1'b0, csrPkg::FLAGS_NONE, 32'd0);
    addRead(csrPkg::ADDR_MCYCLE, csrPkg::FLAGS_NONE, d[4]);
    addRead(csrPkg::ADDR_MCYCLEH, csrPkg::FLAGS_NONE, d[5]);
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MINSTRET, d[0], 5'd0, 1'b0, csrPkg::FLAGS_NONE, 32'd0);
    retireLevel = 2'b11;
    stimTable.push_back(makeRow(ROW_IDLE));
    retireLevel = 2'b01;
    stimTable.push_back(makeRow(ROW_IDLE));
    retireLevel = 2'b10;
    stimTable.push_back(makeRow(ROW_IDLE));
    retireLevel = 2'b00;
    addRead(csrPkg::ADDR_MINSTRET, csrPkg::FLAGS_NONE, d[0] + 32'd4);

    // drop to user mode and probe legality there
    addOp(csrPkg::CSR_RC, csrPkg::ADDR_MSTATUS, 32'h1800, 5'd0, 1'b1, csrPkg::FLAGS_ORDERING,
          32'h1800);
    expPriv = csrPkg::PRIV_USER;
    expRetvec = d[1][31:1];
    addMret(csrPkg::FLAGS_XRET);
    addRead(csrPkg::ADDR_MSCRATCH, csrPkg::FLAGS_ILLEGAL, 32'd0);
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MARCHID, d[2], 5'd0, 1'b1, csrPkg::FLAGS_ILLEGAL, 32'd0);
    addMret(csrPkg::FLAGS_ILLEGAL);
    addRead(csrPkg::ADDR_CYCLE, csrPkg::FLAGS_ILLEGAL, 32'd0); // mcounteren.cy still clear
    expPriv = csrPkg::PRIV_MACHINE;
    addTrap(1'b0, 5'd8, d[3], 32'd0);
    addRead(csrPkg::ADDR_MSTATUS, csrPkg::FLAGS_NONE, 32'd0);
    addOp(csrPkg::CSR_RW, csrPkg::ADDR_MCOUNTEREN, 32'h1, 5'd0, 1'b1, csrPkg::FLAGS_ORDERING,
          32'd0);
    expPriv = csrPkg::PRIV_USER;
    expRetvec = d[3][31:1];
    addMret(csrPkg::FLAGS_XRET);
    addRead(csrPkg::ADDR_CYCLE, csrPkg::FLAGS_NONE, d[4]);
    addRead(csrPkg::ADDR_CYCLEH, csrPkg::FLAGS_NONE, d[5]);
    expPriv = csrPkg::PRIV_MACHINE;
    addTrap(1'b0, 5'd8, d[2], 32'd0);

    // interrupts with meie and mtie already set in mie
    addOp(csrPkg::CSR_RS, csrPkg::ADDR_MSTATUS, 32'h8, 5'd0, 1'b1, csrPkg::FLAGS_ORDERING, 32'd0);
    irqLevel = 1'b1;
    expPending = 1'b1;
    expCause = 5'd11;
    stimTable.push_back(makeRow(ROW_IDLE));
    timerLevel = 1'b1;
    stimTable.push_back(makeRow(ROW_IDLE)); // external still wins
    addRead(csrPkg::ADDR_MIP, csrPkg::FLAGS_NONE, 32'h880);
    irqLevel = 1'b0;
    expCause = 5'd7;
    stimTable.push_back(makeRow(ROW_IDLE));
    expPending = 1'b0;
    addOp(csrPkg::CSR_RC, csrPkg::ADDR_MSTATUS, 32'h8, 5'd0, 1'b1, csrPkg::FLAGS_ORDERING, 32'h8);
    stimTable.push_back(makeRow(ROW_IDLE));
    // user mode takes the timer interrupt even with mstatus.mie clear
    expPriv = csrPkg::PRIV_USER;
    expRetvec = d[2][31:1];
    expPending = 1'b1;
    addMret(csrPkg::FLAGS_XRET);
    stimTable.push_back(makeRow(ROW_IDLE));
  endtask

  task automatic applyRow(input stimRowT r);
    op.valid = r.kind == ROW_OP;
    op.opcode = r.opcode;
    op.addr = r.addr;
    op.srcA = r.src;
    op.zimm = r.zimm;
    op.wantResult = r.wantResult;
    trap.valid = r.kind == ROW_TRAP;
    trap.isInterrupt = r.isInterrupt;
    trap.cause = r.cause;
    trap.pc = r.src;
    trap.tval = r.tval;
    retire = r.retire;
    irq = r.irq;
    mtime = r.timerHit ? mtimecmp : mtimecmp - 64'd1;
  endtask

  task automatic reportMismatch(input string name, input int idx,
                                input logic [31:0] expected, input logic [31:0] actual);
    $display("Fail %s at row %0d: expected 0x%h, got 0x%h", name, idx, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic checkRow(input stimRowT r, input int idx);
    assert (result.valid == (r.kind == ROW_OP))
      else reportMismatch("result.valid", idx, 32'(r.kind == ROW_OP), 32'(result.valid));
    if (r.kind == ROW_OP) begin
      assert (result.flags == r.expFlags)
        else reportMismatch("result.flags", idx, 32'(r.expFlags), 32'(result.flags));
      assert (result.data == r.expData)
        else reportMismatch("result.data", idx, r.expData, result.data);
    end
    assert (trapControl.priv == r.expPriv)
      else reportMismatch("trapControl.priv", idx, 32'(r.expPriv), 32'(trapControl.priv));
    assert (trapControl.mtvecBase == r.expMtvecBase)
      else reportMismatch("trapControl.mtvecBase", idx, 32'(r.expMtvecBase),
                          32'(trapControl.mtvecBase));
    assert (trapControl.retvec == r.expRetvec)
      else reportMismatch("trapControl.retvec", idx, 32'(r.expRetvec), 32'(trapControl.retvec));
    assert (trapControl.interruptPending == r.expPending)
      else reportMismatch("trapControl.interruptPending", idx, 32'(r.expPending),
                          32'(trapControl.interruptPending));
    if (r.expPending) begin // cause only means something while pending
      assert (trapControl.interruptCause == r.expCause)
        else reportMismatch("trapControl.interruptCause", idx, 32'(r.expCause),
                            32'(trapControl.interruptCause));
    end
  endtask

  initial begin
    rst = 1'b1;
    op = '0;
    trap = '0;
    retire = '0;
    irq = 1'b0;
    mtimecmp = 64'h0000_0001_0000_0000; // straddles the word boundary
    mtime = 64'h0000_0000_ffff_ffff;
    buildTable();
    timeoutLimit = 2 * stimTable.size() + 50;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < stimTable.size(); i++) begin
      applyRow(stimTable[i]);
      @(posedge clk);
      #1;
      checkRow(stimTable[i], i);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
source/csrPkg.sv
source/csrReadMux.sv
source/csrCounters.sv
source/interruptCtrl.sv
source/machineTrapRegs.sv
source/csrOpExec.sv
source/csrUnit.sv
verification/csrUnitTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = csrUnitTb
FILELIST = src.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
